//--- design/cnn_pkg.sv
// sizes are fixed for one 16x16 frame of 4-bit pixels, so the derived widths must be rechecked if any changes
`default_nettype none

package cnn_pkg;

	// input frame, streamed in raster order
	localparam int img_w = 16;
	localparam int img_h = 16;
	localparam int pixel_w = 4;

	// laplacian output, 4*15 at most in either direction
	localparam int lap_w = 7;
	localparam int lap_w_out = img_w - 2;
	localparam int lap_h_out = img_h - 2;

	// pattern kernel, weights arrive already filtered
	localparam int weight_w = 8;
	localparam int kernel_taps = 9;

	// correlation output, nine 15-bit products need 19 bits so one spare is kept
	localparam int corr_w = 20;
	localparam int corr_w_out = lap_w_out - 2;
	localparam int corr_h_out = lap_h_out - 2;

	// 2x2 pooling without overlap
	localparam int pool_w_out = corr_w_out / 2;
	localparam int pool_count = pool_w_out * (corr_h_out / 2);

	// detection count, wide enough to hold pool_count
	localparam int count_w = 6;

	// a pooled value is a hit when it is greater than or equal to this
	localparam logic signed [corr_w-1:0] detect_threshold = corr_w'(200);

	typedef struct packed {
		logic valid;
		logic [pixel_w-1:0] pixel;
	} pixel_t;

	typedef struct packed {
		logic valid;
		logic signed [weight_w-1:0] weight;
	} weight_load_t;

	typedef struct packed {
		logic valid;
		logic signed [lap_w-1:0] value;
	} lap_sample_t;

	typedef struct packed {
		logic valid;
		logic signed [corr_w-1:0] value;
	} corr_sample_t;

	typedef struct packed {
		logic valid;
		logic [count_w-1:0] count;
	} detect_result_t;

	// row phase of the pooling stage
	typedef enum logic {
		pool_even_row,
		pool_odd_row
	} pool_phase_t;

endpackage

`default_nettype wire

//--- design/correlation_stage.sv
// weights must be loaded between frames; the last nine loaded apply, in raster order
`default_nettype none

module correlation_stage (
	input logic clk,
	input logic rst,
	input cnn_pkg::lap_sample_t lap_in,
	input cnn_pkg::weight_load_t weight_in,
	output cnn_pkg::corr_sample_t corr_out
);

	localparam int lw = cnn_pkg::lap_w;
	localparam int taps = cnn_pkg::kernel_taps;

	logic win_valid;
	logic [taps*lw-1:0] win;
	logic signed [cnn_pkg::weight_w-1:0] weights [taps];
	logic signed [cnn_pkg::corr_w-1:0] tap_ext [taps];
	logic signed [cnn_pkg::corr_w-1:0] weight_ext [taps];
	logic signed [cnn_pkg::corr_w-1:0] products [taps];
	logic products_valid;
	logic signed [cnn_pkg::corr_w-1:0] sum;

	window_3x3 #(
		.sample_w(lw),
		.row_len(cnn_pkg::lap_w_out),
		.row_count(cnn_pkg::lap_h_out)
	) window_inst (
		.clk(clk),
		.rst(rst),
		.in_valid(lap_in.valid),
		.in_sample(lap_in.value),
		.win_valid(win_valid),
		.win(win)
	);

	// weights shift towards tap 0, so after nine loads the first one sits there
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < taps; k++) begin
				weights[k] <= '0;
			end
		end else if (weight_in.valid) begin
			for (int k = 0; k < taps - 1; k++) begin
				weights[k] <= weights[k+1];
			end
			weights[taps-1] <= weight_in.weight;
		end
	end

	// both operands are sign extended to the full result width
	always_comb begin
		for (int k = 0; k < taps; k++) begin
			tap_ext[k] = {{(cnn_pkg::corr_w - lw){win[k*lw+lw-1]}}, win[k*lw +: lw]};
			weight_ext[k] = {{(cnn_pkg::corr_w - cnn_pkg::weight_w){weights[k][cnn_pkg::weight_w-1]}},
				weights[k]};
		end
		sum = '0;
		for (int k = 0; k < taps; k++) begin
			sum = sum + products[k];
		end
	end

	// first cycle registers the products, second registers their sum
	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int k = 0; k < taps; k++) begin
				products[k] <= tap_ext[k] * weight_ext[k];
			end
		end
		if (products_valid) begin
			corr_out.value <= sum;
		end
		if (rst) begin
			products_valid <= 1'b0;
			corr_out.valid <= 1'b0;
		end else begin
			products_valid <= win_valid;
			corr_out.valid <= products_valid;
		end
	end

endmodule

`default_nettype wire

//--- design/detect_counter.sv
// a frame is closed by its 36th pooled sample, so a lost sample shifts every later frame
`default_nettype none

module detect_counter (
	input logic clk,
	input logic rst,
	input cnn_pkg::corr_sample_t pool_in,
	output cnn_pkg::detect_result_t result
);

	logic [cnn_pkg::count_w-1:0] sample_cnt;
	logic [cnn_pkg::count_w-1:0] hit_cnt;
	logic [cnn_pkg::count_w-1:0] hit_inc;
	logic last_sample;

	assign hit_inc = {{(cnn_pkg::count_w - 1){1'b0}}, (pool_in.value >= cnn_pkg::detect_threshold)};
	assign last_sample = pool_in.valid && (sample_cnt == cnn_pkg::pool_count - 1);

	always_ff @(posedge clk) begin
		if (last_sample) begin
			result.count <= hit_cnt + hit_inc;
		end
		if (rst) begin
			sample_cnt <= '0;
			hit_cnt <= '0;
			result.valid <= 1'b0;
		end else begin
			result.valid <= last_sample;
			// both counts start over once the frame is reported
			if (last_sample) begin
				sample_cnt <= '0;
				hit_cnt <= '0;
			end else if (pool_in.valid) begin
				sample_cnt <= sample_cnt + 1'b1;
				hit_cnt <= hit_cnt + hit_inc;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/laplacian_stage.sv
// interior pixels only, so each 16x16 frame yields 14x14 results one cycle after the completing pixel
`default_nettype none

module laplacian_stage (
	input logic clk,
	input logic rst,
	input cnn_pkg::pixel_t pixel_in,
	output cnn_pkg::lap_sample_t lap_out
);

	localparam int pw = cnn_pkg::pixel_w;
	localparam int pad = cnn_pkg::lap_w - cnn_pkg::pixel_w;

	logic win_valid;
	logic [9*pw-1:0] win;
	logic signed [cnn_pkg::lap_w-1:0] centre;
	logic signed [cnn_pkg::lap_w-1:0] edge_sum;
	logic signed [cnn_pkg::lap_w-1:0] lap_value;

	window_3x3 #(
		.sample_w(pw),
		.row_len(cnn_pkg::img_w),
		.row_count(cnn_pkg::img_h)
	) window_inst (
		.clk(clk),
		.rst(rst),
		.in_valid(pixel_in.valid),
		.in_sample(pixel_in.pixel),
		.win_valid(win_valid),
		.win(win)
	);

	// pixels are unsigned, so they are zero extended before the subtraction
	always_comb begin
		centre = {{pad{1'b0}}, win[4*pw +: pw]};
		edge_sum = {{pad{1'b0}}, win[1*pw +: pw]} + {{pad{1'b0}}, win[3*pw +: pw]}
			+ {{pad{1'b0}}, win[5*pw +: pw]} + {{pad{1'b0}}, win[7*pw +: pw]};
		lap_value = (centre <<< 2) - edge_sum;
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			lap_out.value <= lap_value;
		end
		if (rst) begin
			lap_out.valid <= 1'b0;
		end else begin
			lap_out.valid <= win_valid;
		end
	end

endmodule

`default_nettype wire

//--- design/max_pool_stage.sv
// expects full 12x12 frames with an even row count, so the phase is back on an even row at frame end
`default_nettype none

module max_pool_stage (
	input logic clk,
	input logic rst,
	input cnn_pkg::corr_sample_t corr_in,
	output cnn_pkg::corr_sample_t pool_out
);

	localparam int col_bits = $clog2(cnn_pkg::corr_w_out);

	logic [col_bits-1:0] col;
	cnn_pkg::pool_phase_t phase;
	logic [$clog2(cnn_pkg::pool_w_out)-1:0] pair_idx;
	logic signed [cnn_pkg::corr_w-1:0] first_value;
	logic signed [cnn_pkg::corr_w-1:0] pair_max;
	logic signed [cnn_pkg::corr_w-1:0] block_max;
	logic signed [cnn_pkg::corr_w-1:0] row_buf [cnn_pkg::pool_w_out];
	logic block_done;

	// column pairs (0,1), (2,3) and so on share one buffer entry
	assign pair_idx = col[col_bits-1:1];
	assign block_done = corr_in.valid && col[0] && (phase == cnn_pkg::pool_odd_row);

	always_comb begin
		pair_max = (corr_in.value > first_value) ? corr_in.value : first_value;
		block_max = (pair_max > row_buf[pair_idx]) ? pair_max : row_buf[pair_idx];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			phase <= cnn_pkg::pool_even_row;
		end else if (corr_in.valid) begin
			if (col == cnn_pkg::corr_w_out - 1) begin
				col <= '0;
				if (phase == cnn_pkg::pool_even_row) begin
					phase <= cnn_pkg::pool_odd_row;
				end else begin
					phase <= cnn_pkg::pool_even_row;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// the left sample of a pair waits here; even rows park the pair maximum for the odd row
	always_ff @(posedge clk) begin
		if (corr_in.valid) begin
			if (!col[0]) begin
				first_value <= corr_in.value;
			end else if (phase == cnn_pkg::pool_even_row) begin
				row_buf[pair_idx] <= pair_max;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (block_done) begin
			pool_out.value <= block_max;
		end
		if (rst) begin
			pool_out.valid <= 1'b0;
		end else begin
			pool_out.valid <= block_done;
		end
	end

endmodule

`default_nettype wire

//--- design/pattern_detector.sv
// no back-pressure anywhere; result arrives 5 cycles after the last pixel of a frame
`default_nettype none

module pattern_detector (
	input logic clk,
	input logic rst,
	input cnn_pkg::pixel_t pixel_in,
	input cnn_pkg::weight_load_t weight_in,
	output cnn_pkg::detect_result_t result
);

	cnn_pkg::lap_sample_t lap_sample;
	cnn_pkg::corr_sample_t corr_sample;
	cnn_pkg::corr_sample_t pool_sample;

	// edge filter over the raw pixels
	laplacian_stage laplacian_inst (
		.clk(clk),
		.rst(rst),
		.pixel_in(pixel_in),
		.lap_out(lap_sample)
	);

	// match against the loaded pattern
	correlation_stage correlation_inst (
		.clk(clk),
		.rst(rst),
		.lap_in(lap_sample),
		.weight_in(weight_in),
		.corr_out(corr_sample)
	);

	max_pool_stage max_pool_inst (
		.clk(clk),
		.rst(rst),
		.corr_in(corr_sample),
		.pool_out(pool_sample)
	);

	// one count per frame
	detect_counter detect_inst (
		.clk(clk),
		.rst(rst),
		.pool_in(pool_sample),
		.result(result)
	);

endmodule

`default_nettype wire

//--- design/window_3x3.sv
// the newest window column is combinational from the current sample; row_len and row_count must be at least 3
`default_nettype none

module window_3x3 #(
	parameter int sample_w = 4,
	parameter int row_len = 16,
	parameter int row_count = 16
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic [sample_w-1:0] in_sample,
	output logic win_valid,
	output logic [9*sample_w-1:0] win
);

	logic [$clog2(row_len)-1:0] col;
	logic [$clog2(row_count)-1:0] row;

	// line buffers, indexed by column
	logic [sample_w-1:0] line_prev [row_len];
	logic [sample_w-1:0] line_older [row_len];

	// window columns, entry 0 is the top row
	logic [sample_w-1:0] col_now [3];
	logic [sample_w-1:0] col_prev [3];
	logic [sample_w-1:0] col_older [3];

	// the current column comes straight from the line buffers and the input
	always_comb begin
		col_now[0] = line_older[col];
		col_now[1] = line_prev[col];
		col_now[2] = in_sample;
	end

	// taps in raster order, tap 0 in the low bits and tap 8 (the newest sample) on top
	assign win = {col_now[2], col_prev[2], col_older[2],
		col_now[1], col_prev[1], col_older[1],
		col_now[0], col_prev[0], col_older[0]};

	// a window is complete only once two full rows and two columns precede it
	assign win_valid = in_valid && (row >= 2) && (col >= 2);

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
		end else if (in_valid) begin
			if (col == row_len - 1) begin
				col <= '0;
				if (row == row_count - 1) begin
					row <= '0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			line_older[col] <= line_prev[col];
			line_prev[col] <= in_sample;
			for (int r = 0; r < 3; r++) begin
				col_older[r] <= col_prev[r];
				col_prev[r] <= col_now[r];
			end
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for failures
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f sources.f \
	--top-module pattern_detector_tb \
	-o sim_pattern_detector

./obj_dir/sim_pattern_detector | tee sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation finished without failures"

//--- sources.f
design/cnn_pkg.sv
design/window_3x3.sv
design/laplacian_stage.sv
design/correlation_stage.sv
design/max_pool_stage.sv
design/detect_counter.sv
design/pattern_detector.sv
testbench/pattern_detector_assert.sv
testbench/pattern_detector_tb.sv

//--- testbench/pattern_detector_assert.sv
// watches only the result output of pattern_detector, and is bound to every instance of it
`default_nettype none

module pattern_detector_assert (
	input logic clk,
	input logic rst,
	input cnn_pkg::detect_result_t result
);

	timeunit 1ns;
	timeprecision 1ps;

	// a frame report is a one cycle pulse
	valid_single_cycle: assert property (
		@(posedge clk) disable iff (rst) result.valid |=> !result.valid
	) else $error("result valid stayed high for two cycles");

	// a frame has only 36 pooled values to count
	count_in_range: assert property (
		@(posedge clk) disable iff (rst) result.valid |-> result.count <= cnn_pkg::pool_count
	) else $error("result count above the number of pooled values");

	// reset clears the result strobe by the next cycle
	valid_low_after_reset: assert property (
		@(posedge clk) rst |=> !result.valid
	) else $error("result valid high in the cycle after reset");

endmodule

bind pattern_detector pattern_detector_assert assert_inst (
	.clk(clk),
	.rst(rst),
	.result(result)
);

`default_nettype wire

//--- testbench/pattern_detector_tb.sv
// weights are loaded only between frames; the run is capped at 4000 cycles and stops early on a timeout
`default_nettype none

module pattern_detector_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// five frames of 256 pixels, one of them with up to three idle cycles per pixel, plus loads
	localparam int timeout_cycles = 4000;
	localparam int frame_pixels = 256;

	typedef int frame_t [256];
	typedef int kernel_t [9];

	logic clk;
	logic rst;
	cnn_pkg::pixel_t pixel_in;
	cnn_pkg::weight_load_t weight_in;
	cnn_pkg::detect_result_t result;

	int seed;
	int cycle_count;
	int value_errors;
	int other_errors;
	int expected;
	int expected_q [$];
	frame_t frame_a;
	frame_t frame_b;
	kernel_t kernel_a;
	kernel_t kernel_b;

	pattern_detector pattern_detector_inst (
		.clk(clk),
		.rst(rst),
		.pixel_in(pixel_in),
		.weight_in(weight_in),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// edge filter, correlation, 2x2 pooling and threshold, written straight from the frame rules
	function automatic int reference_count(input frame_t img, input kernel_t w);
		int lap [196];
		int corr [144];
		int hits;
		int best;
		int v;
		hits = 0;
		for (int y = 1; y < 15; y++) begin
			for (int x = 1; x < 15; x++) begin
				lap[(y - 1) * 14 + (x - 1)] = 4 * img[y * 16 + x] - img[(y - 1) * 16 + x]
					- img[(y + 1) * 16 + x] - img[y * 16 + x - 1] - img[y * 16 + x + 1];
			end
		end
		for (int y = 0; y < 12; y++) begin
			for (int x = 0; x < 12; x++) begin
				v = 0;
				for (int i = 0; i < 3; i++) begin
					for (int j = 0; j < 3; j++) begin
						v = v + lap[(y + i) * 14 + x + j] * w[i * 3 + j];
					end
				end
				corr[y * 12 + x] = v;
			end
		end
		for (int py = 0; py < 6; py++) begin
			for (int px = 0; px < 6; px++) begin
				best = corr[(2 * py) * 12 + 2 * px];
				for (int k = 1; k < 4; k++) begin
					v = corr[(2 * py + k / 2) * 12 + 2 * px + k % 2];
					if (v > best) begin
						best = v;
					end
				end
				if (best >= 200) begin
					hits++;
				end
			end
		end
		return hits;
	endfunction

	task automatic random_frame(output frame_t img);
		for (int k = 0; k < frame_pixels; k++) begin
			img[k] = $random(seed) & 15;
		end
	endtask

	// signed weights in -127..127
	task automatic random_kernel(output kernel_t w);
		for (int k = 0; k < 9; k++) begin
			w[k] = $random(seed) % 128;
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (5) begin
			@(negedge clk);
			if (result.valid !== 1'b0) begin
				other_errors++;
				$display("result valid was high while reset was held at %0t", $time);
			end
		end
		rst = 1'b0;
		// nothing may come out before the first pixel
		repeat (4) begin
			@(negedge clk);
			if (result.valid !== 1'b0) begin
				other_errors++;
				$display("result valid rose before any pixel was sent at %0t", $time);
			end
		end
	endtask

	task automatic load_weights(input kernel_t w);
		for (int k = 0; k < 9; k++) begin
			@(negedge clk);
			weight_in.valid = 1'b1;
			weight_in.weight = 8'(w[k]);
		end
		@(negedge clk);
		weight_in.valid = 1'b0;
	endtask

	task automatic send_frame(input frame_t img, input bit with_gaps);
		int gap;
		for (int k = 0; k < frame_pixels; k++) begin
			@(negedge clk);
			pixel_in.valid = 1'b1;
			pixel_in.pixel = 4'(img[k]);
			if (with_gaps) begin
				gap = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
				repeat (gap) begin
					@(negedge clk);
					pixel_in.valid = 1'b0;
				end
			end
		end
		@(negedge clk);
		pixel_in.valid = 1'b0;
	endtask

	// the comparing process pops the queue, so an empty queue means every frame reported
	task automatic wait_results();
		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (3) @(negedge clk);
	endtask

	// result is registered, so it is stable at the falling edge
	always @(negedge clk) begin
		if (!rst && result.valid) begin
			if (expected_q.size() == 0) begin
				other_errors++;
				$display("unexpected result with count %0d at %0t, no frame was outstanding",
					result.count, $time);
			end else begin
				expected = expected_q.pop_front();
				if (int'(result.count) != expected) begin
					value_errors++;
					$display("FAIL %0t: detection count %0d, expected %0d",
						$time, result.count, expected);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout after %0d cycles, results never arrived", cycle_count);
			$display("errors: %0d wrong counts, %0d other failures", value_errors, other_errors);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		seed = 88;
		cycle_count = 0;
		value_errors = 0;
		other_errors = 0;
		rst = 1'b1;
		pixel_in = '0;
		weight_in = '0;
		apply_reset();

		// a flat frame has no edges, so nothing can match
		random_kernel(kernel_a);
		load_weights(kernel_a);
		for (int k = 0; k < frame_pixels; k++) begin
			frame_a[k] = 9;
		end
		expected_q.push_back(reference_count(frame_a, kernel_a));
		send_frame(frame_a, 1'b0);
		wait_results();

		random_frame(frame_a);
		random_kernel(kernel_a);
		load_weights(kernel_a);
		expected_q.push_back(reference_count(frame_a, kernel_a));
		send_frame(frame_a, 1'b0);
		wait_results();

		random_frame(frame_a);
		expected_q.push_back(reference_count(frame_a, kernel_a));
		send_frame(frame_a, 1'b1);
		wait_results();

		// second frame follows right after the new weights
		random_frame(frame_a);
		random_frame(frame_b);
		random_kernel(kernel_a);
		random_kernel(kernel_b);
		load_weights(kernel_a);
		expected_q.push_back(reference_count(frame_a, kernel_a));
		send_frame(frame_a, 1'b0);
		load_weights(kernel_b);
		expected_q.push_back(reference_count(frame_b, kernel_b));
		send_frame(frame_b, 1'b0);
		wait_results();

		$display("errors: %0d wrong counts, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
